// File: logic/alpha_pkg.sv
package alpha_pkg;

	// phase timing
	localparam int phase_ticks = 100; // clock cycles per phase
	localparam int trigger_wait_phases = 20; // long wait before the closing token
	localparam int button_pickoff = 6; // button pipeline depth minus one

	// configuration load
	localparam logic [15:0] config_word = 16'hf0a5;
	localparam int config_bits = 20; // 16 data bits, then 4 dummy bits

	// counter types, sized from the constants above
	typedef logic [$clog2(phase_ticks)-1:0] phase_count_t;
	typedef logic [$clog2(trigger_wait_phases)-1:0] wait_count_t;
	typedef logic [$clog2(config_bits)-1:0] bit_count_t;

	// sequencer states, startup phases in output order, then load
	typedef enum logic [3:0] {
		seq_idle,
		seq_lead,
		seq_dreset,
		seq_settle,
		seq_sync,
		seq_gap_a,
		seq_token,
		seq_gap_b,
		seq_trigger,
		seq_trigger_wait,
		seq_token_end,
		seq_load
	} seq_state_t;

	// control lines to the ALPHA asic
	typedef struct packed {
		logic dreset;
		logic sync;
		logic token; // tok_a_f2t on the board
		logic trigger; // trig_top on the board
	} asic_ctrl_t;

	// configuration serial port
	typedef struct packed {
		logic sin;
		logic sclk;
	} serial_t;

endpackage

// File: logic/button_edge.sv
`timescale 1ns/10ps

module button_edge (
	input  logic clock,
	input  logic reset,
	input  logic button,
	output logic pulse
);
	logic [1:0] button_sync; // raw button is asynchronous to clock
	logic [alpha_pkg::button_pickoff:0] pipeline; // newest sample in bit 0

	always_ff @(posedge clock) begin
		if (reset) begin
			button_sync <= '0;
			pipeline <= '0;
			pulse <= 1'b0;
		end else begin
			button_sync <= {button_sync[0], button};
			pipeline <= {pipeline[alpha_pkg::button_pickoff-1:0], button_sync[1]};
			// oldest bit still low, next one high
			pulse <= (pipeline[alpha_pkg::button_pickoff -: 2] == 2'b01);
		end
	end

endmodule

// File: logic/phase_timer.sv
`timescale 1ns/10ps

module phase_timer (
	input  logic clock,
	input  logic reset,
	input  logic timer_run,
	output logic phase_tick
);
	alpha_pkg::phase_count_t count; // cycles into the current phase
	logic last_cycle;

	// last cycle of a phase
	assign last_cycle = (count == alpha_pkg::phase_count_t'(alpha_pkg::phase_ticks - 1));

	// tick only while running, so a stopped timer never advances anything
	assign phase_tick = timer_run && last_cycle;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (!timer_run) begin
			count <= '0; // restart, first phase is full length
		end else if (last_cycle) begin
			count <= '0; // wrap into the next phase
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: logic/sequence_fsm.sv
`timescale 1ns/10ps

module sequence_fsm (
	input  logic clock,
	input  logic reset,
	input  logic startup_pulse,
	input  logic load_pulse,
	input  logic phase_tick,
	input  logic shift_ack,
	output logic timer_run,
	output logic shift_req,
	output alpha_pkg::asic_ctrl_t ctrl,
	output logic busy
);
	alpha_pkg::seq_state_t state;
	alpha_pkg::seq_state_t state_next;
	alpha_pkg::wait_count_t wait_count; // phases spent in trigger wait
	logic wait_done;
	alpha_pkg::asic_ctrl_t ctrl_next;

	assign wait_done =
		(wait_count == alpha_pkg::wait_count_t'(alpha_pkg::trigger_wait_phases - 1));

	assign busy = (state != alpha_pkg::seq_idle);
	assign timer_run = (state != alpha_pkg::seq_idle); // timer held clear when idle

	always_comb begin
		state_next = state;
		case (state)
			alpha_pkg::seq_idle: begin
				if (startup_pulse) begin
					state_next = alpha_pkg::seq_lead; // startup wins a tie
				end else if (load_pulse) begin
					state_next = alpha_pkg::seq_load;
				end
			end
			alpha_pkg::seq_lead: if (phase_tick) state_next = alpha_pkg::seq_dreset;
			alpha_pkg::seq_dreset: if (phase_tick) state_next = alpha_pkg::seq_settle;
			alpha_pkg::seq_settle: if (phase_tick) state_next = alpha_pkg::seq_sync;
			alpha_pkg::seq_sync: if (phase_tick) state_next = alpha_pkg::seq_gap_a;
			alpha_pkg::seq_gap_a: if (phase_tick) state_next = alpha_pkg::seq_token;
			alpha_pkg::seq_token: if (phase_tick) state_next = alpha_pkg::seq_gap_b;
			alpha_pkg::seq_gap_b: if (phase_tick) state_next = alpha_pkg::seq_trigger;
			alpha_pkg::seq_trigger: if (phase_tick) state_next = alpha_pkg::seq_trigger_wait;
			alpha_pkg::seq_trigger_wait: begin
				if (phase_tick && wait_done) begin
					state_next = alpha_pkg::seq_token_end;
				end
			end
			alpha_pkg::seq_token_end: if (phase_tick) state_next = alpha_pkg::seq_idle;
			alpha_pkg::seq_load: begin
				// handshake fully closed, both lines back low
				if (!shift_req && !shift_ack) begin
					state_next = alpha_pkg::seq_idle;
				end
			end
			default: state_next = alpha_pkg::seq_idle;
		endcase
	end

	// control lines decoded from the current state
	always_comb begin
		ctrl_next = '0;
		ctrl_next.dreset = (state == alpha_pkg::seq_dreset);
		ctrl_next.sync = (state == alpha_pkg::seq_sync);
		ctrl_next.token = (state == alpha_pkg::seq_token) ||
			(state == alpha_pkg::seq_token_end); // second token closes the readout
		ctrl_next.trigger = (state == alpha_pkg::seq_trigger);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_pkg::seq_idle;
			wait_count <= '0;
			shift_req <= 1'b0;
			ctrl <= '0;
		end else begin
			state <= state_next;
			ctrl <= ctrl_next; // one cycle behind the state
			if (state != alpha_pkg::seq_trigger_wait) begin
				wait_count <= '0;
			end else if (phase_tick) begin
				wait_count <= wait_count + 1'b1;
			end
			// four-phase handshake with the shifter
			if (state == alpha_pkg::seq_idle && state_next == alpha_pkg::seq_load) begin
				shift_req <= 1'b1;
			end else if (shift_ack) begin
				shift_req <= 1'b0;
			end
		end
	end

endmodule

// File: logic/config_shifter.sv
`timescale 1ns/10ps

module config_shifter (
	input  logic clock,
	input  logic reset,
	input  logic shift_req,
	input  logic phase_tick,
	output logic shift_ack,
	output alpha_pkg::serial_t serial
);
	logic req_d; // last shift_req, for the rising edge
	logic active; // bits still to go
	logic [1:0] slot; // 0 set sin, 1 sclk high, 2 sclk low
	alpha_pkg::bit_count_t bit_count;
	logic last_bit;
	logic req_rise;

	assign last_bit = (bit_count == alpha_pkg::bit_count_t'(alpha_pkg::config_bits - 1));
	assign req_rise = shift_req && !req_d;

	always_ff @(posedge clock) begin
		if (reset) begin
			req_d <= 1'b0;
			active <= 1'b0;
			slot <= '0;
			bit_count <= '0;
			shift_ack <= 1'b0;
			serial <= '0;
		end else begin
			req_d <= shift_req;
			if (!shift_req) begin
				shift_ack <= 1'b0; // fsm let go, close the handshake
			end
			if (req_rise) begin
				active <= 1'b1;
				slot <= '0;
				bit_count <= '0;
				serial <= '0;
			end else if (active && phase_tick) begin
				case (slot)
					2'd0: begin
						// dummy bits wrap onto word bits 0 to 3, LSB first
						serial.sin <= alpha_pkg::config_word[bit_count[3:0]];
						slot <= 2'd1;
					end
					2'd1: begin
						serial.sclk <= 1'b1; // asic samples sin here
						slot <= 2'd2;
					end
					default: begin
						serial.sclk <= 1'b0;
						slot <= 2'd0;
						if (last_bit) begin
							active <= 1'b0;
							shift_ack <= 1'b1; // all bits out
						end else begin
							bit_count <= bit_count + 1'b1;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: logic/alpha_sequencer.sv
`timescale 1ns/10ps

module alpha_sequencer (
	input  logic clock,
	input  logic reset,
	input  logic startup_button,
	input  logic load_button,
	output alpha_pkg::asic_ctrl_t ctrl,
	output alpha_pkg::serial_t serial,
	output logic busy
);
	logic startup_pulse; // one cycle per startup press
	logic load_pulse; // one cycle per load press
	logic timer_run;
	logic phase_tick;
	logic shift_req; // fsm to shifter
	logic shift_ack; // shifter back to fsm

	button_edge startup_edge_i (
		.clock(clock),
		.reset(reset),
		.button(startup_button),
		.pulse(startup_pulse)
	);

	button_edge load_edge_i (
		.clock(clock),
		.reset(reset),
		.button(load_button),
		.pulse(load_pulse)
	);

	phase_timer phase_timer_i (
		.clock(clock),
		.reset(reset),
		.timer_run(timer_run),
		.phase_tick(phase_tick)
	);

	// one fsm owns both operations, so only one runs at a time
	sequence_fsm sequence_fsm_i (
		.clock(clock),
		.reset(reset),
		.startup_pulse(startup_pulse),
		.load_pulse(load_pulse),
		.phase_tick(phase_tick),
		.shift_ack(shift_ack),
		.timer_run(timer_run),
		.shift_req(shift_req),
		.ctrl(ctrl),
		.busy(busy)
	);

	config_shifter config_shifter_i (
		.clock(clock),
		.reset(reset),
		.shift_req(shift_req),
		.phase_tick(phase_tick),
		.shift_ack(shift_ack),
		.serial(serial)
	);

endmodule

// File: include/alpha_tb_ref.svh
`ifndef ALPHA_TB_REF_SVH
`define ALPHA_TB_REF_SVH

// cycles from the start pulse until busy drops after a startup
function automatic int startup_length();
	return (9 + alpha_pkg::trigger_wait_phases) * alpha_pkg::phase_ticks;
endfunction

// expected control lines, offset 0 is the cycle with the start pulse high
function automatic alpha_pkg::asic_ctrl_t expected_ctrl(input int offset);
	int phase;
	alpha_pkg::asic_ctrl_t exp;
	exp = '0;
	if (offset >= 2) begin
		// state enters one cycle after the pulse, outputs one more behind
		phase = (offset - 2) / alpha_pkg::phase_ticks;
		exp.dreset = (phase == 1);
		exp.sync = (phase == 3);
		exp.token = (phase == 5) || (phase == 8 + alpha_pkg::trigger_wait_phases);
		exp.trigger = (phase == 7);
	end
	return exp;
endfunction

// bit n on sin, the dummy bits repeat the low word bits
function automatic logic expected_sin(input int n);
	return alpha_pkg::config_word[n % $bits(alpha_pkg::config_word)];
endfunction

task automatic check_value(
	input string name,
	input logic [31:0] expected,
	input logic [31:0] actual,
	ref int errors
);
	if (expected !== actual) begin
		$display("Error %s expected %h got %h", name, expected, actual);
		errors++;
	end
endtask

`endif

// File: testbench/alpha_sequencer_tb.sv
`timescale 1ns/10ps

module alpha_sequencer_tb;

	// operation lengths in phases, for the watchdog
	localparam int startup_phases = 9 + alpha_pkg::trigger_wait_phases;
	localparam int load_phases = 3 * alpha_pkg::config_bits; // three slots per bit
	// idle 2, three startups, three loads (last one cut by reset), gaps
	localparam int test_phases = 2 + 3 * startup_phases + 3 * load_phases + 9;
	localparam int timeout_cycles = 2 * test_phases * alpha_pkg::phase_ticks;
	localparam int load_min = load_phases * alpha_pkg::phase_ticks; // busy at least this long

	typedef enum {watch_off, watch_idle, watch_startup, watch_load} watch_t;

	logic clock;
	logic reset;
	logic startup_button;
	logic load_button;
	alpha_pkg::asic_ctrl_t ctrl;
	alpha_pkg::serial_t serial;
	logic busy;

	int cycle_count = 0; // rising edges since time zero
	int error_count = 0;
	int pulse_cycle = 0; // cycle with the start pulse high
	int sclk_edges = 0; // rising sclk edges of the running load
	logic sclk_prev = 1'b0;
	watch_t watch = watch_off;

	`include "alpha_tb_ref.svh"

	alpha_sequencer alpha_sequencer_i (
		.clock(clock),
		.reset(reset),
		.startup_button(startup_button),
		.load_button(load_button),
		.ctrl(ctrl),
		.serial(serial),
		.busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	always @(posedge clock) cycle_count <= cycle_count + 1;

	// expected busy during a startup, same offset origin as expected_ctrl
	function automatic logic startup_busy(input int offset);
		return (offset >= 1) && (offset <= startup_length());
	endfunction

	// mid-cycle compare of the outputs
	always @(negedge clock) begin : monitor
		int offset;
		offset = cycle_count - pulse_cycle;
		case (watch)
			watch_idle: begin
				check_value("ctrl", 32'h0, ctrl, error_count);
				check_value("busy", 32'h0, busy, error_count);
				check_value("serial.sclk", 32'h0, serial.sclk, error_count);
			end
			watch_startup: begin
				check_value("ctrl", expected_ctrl(offset), ctrl, error_count);
				check_value("busy", startup_busy(offset), busy, error_count);
				check_value("serial.sclk", 32'h0, serial.sclk, error_count);
			end
			watch_load: begin
				check_value("ctrl", 32'h0, ctrl, error_count); // no asic lines during load
				if (offset >= 1 && offset <= load_min) begin
					check_value("busy", 32'h1, busy, error_count);
				end
				if (serial.sclk && !sclk_prev) begin
					// sin settled one phase before sclk rose
					check_value($sformatf("serial.sin bit %0d", sclk_edges),
						expected_sin(sclk_edges), serial.sin, error_count);
					sclk_edges++;
				end
			end
			default: ;
		endcase
		sclk_prev = serial.sclk;
	end

	// counts, then the status line, then stop
	task automatic finish_run(input bit timed_out);
		$display("errors %0d, timeouts %0d", error_count, timed_out);
		if (!timed_out && error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	// called on a falling edge, returns on one
	task automatic press_button(input bit load);
		int hold;
		hold = 5 + ($urandom % 26);
		if (load) load_button = 1'b1;
		else startup_button = 1'b1;
		repeat (hold) @(negedge clock);
		startup_button = 1'b0;
		load_button = 1'b0;
	endtask

	// anchor the reference on this press, sampled at the next rising edge
	task automatic start_operation(input bit load);
		pulse_cycle = cycle_count + 1 + alpha_pkg::button_pickoff + 2;
		sclk_edges = 0;
		watch = load ? watch_load : watch_startup;
		press_button(load);
	endtask

	task automatic wait_busy_fall();
		while (busy !== 1'b1) @(negedge clock);
		while (busy !== 1'b0) @(negedge clock);
	endtask

	task automatic wait_phases(input int phases);
		repeat (phases * alpha_pkg::phase_ticks) @(negedge clock);
	endtask

	// runs one load to the end and checks its bit count and length
	task automatic run_load();
		int load_cycles;
		start_operation(1'b1);
		wait_busy_fall();
		load_cycles = cycle_count - pulse_cycle;
		check_value("sclk rising edges", alpha_pkg::config_bits, sclk_edges, error_count);
		if (load_cycles <= load_min || load_cycles > load_min + alpha_pkg::phase_ticks) begin
			$display("load took %0d cycles, outside the expected window", load_cycles);
			error_count++;
		end
		@(negedge clock);
	endtask

	initial begin : watchdog
		alpha_pkg::seq_state_t stuck_state;
		while (cycle_count < timeout_cycles) @(posedge clock);
		stuck_state = alpha_sequencer_i.sequence_fsm_i.state;
		$display("timeout: run passed %0d cycles with the sequencer in %s",
			timeout_cycles, stuck_state.name());
		finish_run(1'b1);
	end

	initial begin : stimulus
		void'($urandom(32'h73cd_5dc4));
		reset = 1'b1;
		startup_button = 1'b0;
		load_button = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// quiet after reset
		check_value("ctrl", 32'h0, ctrl, error_count);
		check_value("serial", 32'h0, serial, error_count);
		check_value("busy", 32'h0, busy, error_count);
		watch = watch_idle;
		wait_phases(2);

		// plain startup
		start_operation(1'b0);
		wait_busy_fall();
		@(negedge clock); // let the last token drop
		watch = watch_idle;
		wait_phases(1);

		run_load();
		watch = watch_idle;
		wait_phases(1);

		// startup with ignored presses in the middle
		start_operation(1'b0);
		wait_phases(5);
		press_button(1'b1);
		wait_phases(10);
		press_button(1'b0);
		wait_busy_fall();
		@(negedge clock);
		watch = watch_idle;
		wait_phases(1);

		// back to back, startup then load
		start_operation(1'b0);
		wait_busy_fall();
		@(negedge clock);
		run_load();
		watch = watch_idle;
		wait_phases(1);

		// reset while sclk is high in a load
		start_operation(1'b1);
		while (serial.sclk !== 1'b1) @(negedge clock);
		wait_phases(3);
		watch = watch_off;
		reset = 1'b1;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		check_value("ctrl", 32'h0, ctrl, error_count);
		check_value("serial", 32'h0, serial, error_count);
		check_value("busy", 32'h0, busy, error_count);
		watch = watch_idle;
		wait_phases(1);

		finish_run(1'b0);
	end

endmodule

// File: verilog.f
+incdir+include
logic/alpha_pkg.sv
logic/button_edge.sv
logic/phase_timer.sv
logic/sequence_fsm.sv
logic/config_shifter.sv
logic/alpha_sequencer.sv
testbench/alpha_sequencer_tb.sv

// File: Bender.yml
package:
  name: alpha_sequencer

sources:
  - files:
      - logic/alpha_pkg.sv
      - logic/button_edge.sv
      - logic/phase_timer.sv
      - logic/sequence_fsm.sv
      - logic/config_shifter.sv
      - logic/alpha_sequencer.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/alpha_sequencer_tb.sv
